/* source/mem_pkg.sv */
/*
 * Data memory geometry shared by the UART writer, the memory and the dump
 */
package mem_pkg;

	// Word address width, small so a test can reach wrap-around
	localparam int MEM_ADDR_W = 5;

	// Number of words
	localparam int MEM_DEPTH = 1 << MEM_ADDR_W;

	// Word width
	localparam int MEM_DATA_W = 32;

	// Byte lanes per word, also the write enable width
	localparam int MEM_LANES = 4;

	// Lane index width inside the byte counter
	localparam int MEM_LANE_W = $clog2(MEM_LANES);

endpackage

/* source/uart_pkg.sv */
/*
 * Serial framing for the UART receiver and transmitter, 8N1 LSB first
 */
package uart_pkg;

	// Data bits per frame
	localparam int UART_DATA_W = 8;

	// Clock cycles per serial bit
	localparam int CLKS_PER_BIT = 16;

	// Offset to the middle of a bit
	localparam int CLKS_HALF_BIT = CLKS_PER_BIT / 2;

	// Cycle counter width within one bit
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

endpackage

/* source/uart_rx_writer.sv */
/*
 * UART receiver with mid-bit sampling
 * Each good byte is written into the data memory at the next byte lane
 */
module uart_rx_writer (
	input  logic                           CLK_BUF,
	input  logic                           reset_i,
	input  logic                           rx_i,
	output logic [mem_pkg::MEM_ADDR_W-1:0] con_addr_o,
	output logic [mem_pkg::MEM_LANES-1:0]  con_write_o,
	output logic [mem_pkg::MEM_DATA_W-1:0] con_in_o,
	output logic                           frame_err_o
);
	import mem_pkg::*;
	import uart_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_start,
		s_data,
		s_stop
	} rx_state_t;

	rx_state_t state_q;

	// Two-flop synchronizer on the serial line
	logic rx_meta_q;
	logic rx_sync_q;

	// Cycle within the current bit
	logic [BIT_CNT_W-1:0] clk_cnt_q;
	// Data bit being received
	logic [$clog2(UART_DATA_W)-1:0] bit_idx_q;
	logic [UART_DATA_W-1:0] shift_q;

	// Upper bits give the word, low bits the lane
	logic [MEM_ADDR_W+MEM_LANE_W-1:0] byte_cnt_q;

	logic bit_end;
	logic half_end;

	assign bit_end = (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
	assign half_end = (clk_cnt_q == BIT_CNT_W'(CLKS_HALF_BIT - 1));

	// Line idles high
	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
		end else begin
			rx_meta_q <= rx_i;
			rx_sync_q <= rx_meta_q;
		end
	end

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			state_q <= s_idle;
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
			byte_cnt_q <= '0;
			con_write_o <= '0;
			frame_err_o <= 1'b0;
		end else begin
			// Single-cycle strobes
			con_write_o <= '0;
			frame_err_o <= 1'b0;
			case (state_q)
				s_idle: begin
					clk_cnt_q <= '0;
					// Falling edge may be a start bit
					if (!rx_sync_q) begin
						state_q <= s_start;
					end
				end
				s_start: begin
					if (half_end) begin
						clk_cnt_q <= '0;
						bit_idx_q <= '0;
						// Line back high by mid-bit means a glitch
						state_q <= rx_sync_q ? s_idle : s_data;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				s_data: begin
					if (bit_end) begin
						clk_cnt_q <= '0;
						bit_idx_q <= bit_idx_q + 1'b1;
						if (int'(bit_idx_q) == UART_DATA_W - 1) begin
							state_q <= s_stop;
						end
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				s_stop: begin
					if (bit_end) begin
						clk_cnt_q <= '0;
						state_q <= s_idle;
						if (rx_sync_q) begin
							// One-hot lane from the low counter bits
							con_write_o <= MEM_LANES'(1) << byte_cnt_q[MEM_LANE_W-1:0];
							// Wraps after the last lane of the last word
							byte_cnt_q <= byte_cnt_q + 1'b1;
						end else begin
							// Bad stop bit, byte dropped
							frame_err_o <= 1'b1;
						end
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	// Payload path
	always_ff @(posedge CLK_BUF) begin
		// LSB arrives first
		if (state_q == s_data && bit_end) begin
			shift_q <= {rx_sync_q, shift_q[UART_DATA_W-1:1]};
		end
		if (state_q == s_stop && bit_end) begin
			con_addr_o <= byte_cnt_q[MEM_ADDR_W+MEM_LANE_W-1:MEM_LANE_W];
			// Byte copied to every lane, enable picks one
			con_in_o <= {MEM_LANES{shift_q}};
		end
	end

endmodule

/* source/data_mem.sv */
/*
 * Data memory with a byte-lane write port and a registered read port
 * Written as a simple dual-port block RAM
 */
module data_mem (
	input  logic                           CLK_BUF,
	input  logic [mem_pkg::MEM_ADDR_W-1:0] con_addr_i,
	input  logic [mem_pkg::MEM_LANES-1:0]  con_write_i,
	input  logic [mem_pkg::MEM_DATA_W-1:0] con_in_i,
	input  logic [mem_pkg::MEM_ADDR_W-1:0] dump_addr_i,
	output logic [mem_pkg::MEM_DATA_W-1:0] dump_data_o
);
	import mem_pkg::*;

	// Storage, cleared at power-up only
	logic [MEM_DATA_W-1:0] mem_q [MEM_DEPTH] = '{default: '0};

	// Port A
	// Each lane stored only when its enable is high
	always_ff @(posedge CLK_BUF) begin
		for (int i = 0; i < MEM_LANES; i++) begin
			if (con_write_i[i]) begin
				mem_q[con_addr_i][i*(MEM_DATA_W/MEM_LANES) +: MEM_DATA_W/MEM_LANES] <=
					con_in_i[i*(MEM_DATA_W/MEM_LANES) +: MEM_DATA_W/MEM_LANES];
			end
		end
	end

	// Port B
	// Data one cycle after the address
	always_ff @(posedge CLK_BUF) begin
		dump_data_o <= mem_q[dump_addr_i];
	end

endmodule

/* source/mem_dump_tx.sv */
/*
 * Memory dump transmitter
 * Reads words 0 to len-1 and sends each one as four 8N1 frames, lane 0 first
 */
module mem_dump_tx (
	input  logic                           CLK_BUF,
	input  logic                           reset_i,
	input  logic                           dump_start_i,
	input  logic [mem_pkg::MEM_ADDR_W:0]   dump_len_i,
	input  logic [mem_pkg::MEM_DATA_W-1:0] dump_data_i,
	output logic [mem_pkg::MEM_ADDR_W-1:0] dump_addr_o,
	output logic                           tx_o,
	output logic                           dump_busy_o
);
	import mem_pkg::*;
	import uart_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_read,
		s_load,
		s_send
	} tx_state_t;

	tx_state_t state_q;

	// Words still to be latched
	logic [MEM_ADDR_W:0] words_left_q;
	logic [MEM_LANE_W-1:0] lane_q;
	logic [BIT_CNT_W-1:0] clk_cnt_q;
	// Start bit, data bits, stop bit
	logic [$clog2(UART_DATA_W+2)-1:0] bit_idx_q;
	// Lanes not yet sent
	logic [MEM_DATA_W-1:0] word_q;
	// Remaining data bits with the stop bit on top
	logic [UART_DATA_W:0] tx_sh_q;

	logic bit_end;
	logic frame_end;
	logic last_lane;

	assign bit_end = (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
	assign frame_end = bit_end && (int'(bit_idx_q) == UART_DATA_W + 1);
	assign last_lane = (lane_q == MEM_LANE_W'(MEM_LANES - 1));

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			state_q <= s_idle;
			dump_busy_o <= 1'b0;
			tx_o <= 1'b1;
			dump_addr_o <= '0;
			words_left_q <= '0;
			lane_q <= '0;
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
		end else begin
			case (state_q)
				s_idle: begin
					// Zero length starts nothing
					if (dump_start_i && dump_len_i != '0) begin
						dump_busy_o <= 1'b1;
						dump_addr_o <= '0;
						words_left_q <= dump_len_i;
						state_q <= s_read;
					end
				end
				s_read: begin
					// Memory registers word 0 here
					state_q <= s_load;
				end
				s_load: begin
					// Word latched, start bit of lane 0
					tx_o <= 1'b0;
					// Prefetch so the next word waits at the read port
					dump_addr_o <= dump_addr_o + 1'b1;
					words_left_q <= words_left_q - 1'b1;
					lane_q <= '0;
					clk_cnt_q <= '0;
					bit_idx_q <= '0;
					state_q <= s_send;
				end
				s_send: begin
					if (bit_end) begin
						clk_cnt_q <= '0;
						if (frame_end) begin
							bit_idx_q <= '0;
							if (!last_lane) begin
								// Next lane follows with no gap
								lane_q <= lane_q + 1'b1;
								tx_o <= 1'b0;
							end else if (words_left_q == '0) begin
								// Busy falls at the end of the last stop bit
								dump_busy_o <= 1'b0;
								state_q <= s_idle;
							end else begin
								// One idle cycle while the next word loads
								state_q <= s_load;
							end
						end else begin
							tx_o <= tx_sh_q[0];
							bit_idx_q <= bit_idx_q + 1'b1;
						end
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	// Word and bit shifters
	always_ff @(posedge CLK_BUF) begin
		if (state_q == s_load) begin
			tx_sh_q <= {1'b1, dump_data_i[UART_DATA_W-1:0]};
			word_q <= dump_data_i >> UART_DATA_W;
		end else if (state_q == s_send && bit_end) begin
			if (frame_end) begin
				// Next lane moves down
				tx_sh_q <= {1'b1, word_q[UART_DATA_W-1:0]};
				word_q <= word_q >> UART_DATA_W;
			end else begin
				tx_sh_q <= {1'b1, tx_sh_q[UART_DATA_W:1]};
			end
		end
	end

endmodule

/* source/periph_top.sv */
/*
 * Peripheral top, UART writer and dump transmitter around the data memory
 */
module periph_top (
	input  logic                         CLK_BUF,
	input  logic                         reset_i,
	input  logic                         rx_i,
	input  logic                         dump_start_i,
	input  logic [mem_pkg::MEM_ADDR_W:0] dump_len_i,
	output logic                         frame_err_o,
	output logic                         tx_o,
	output logic                         dump_busy_o
);
	import mem_pkg::*;

	// Write port from the receiver
	logic [MEM_ADDR_W-1:0] con_addr;
	logic [MEM_LANES-1:0] con_write;
	logic [MEM_DATA_W-1:0] con_in;

	// Read port of the dump
	logic [MEM_ADDR_W-1:0] dump_addr;
	logic [MEM_DATA_W-1:0] dump_data;

	// Producer
	uart_rx_writer i_uart_rx_writer (
		.CLK_BUF(CLK_BUF),
		.reset_i(reset_i),
		.rx_i(rx_i),
		.con_addr_o(con_addr),
		.con_write_o(con_write),
		.con_in_o(con_in),
		.frame_err_o(frame_err_o)
	);

	// Shared buffer
	data_mem i_data_mem (
		.CLK_BUF(CLK_BUF),
		.con_addr_i(con_addr),
		.con_write_i(con_write),
		.con_in_i(con_in),
		.dump_addr_i(dump_addr),
		.dump_data_o(dump_data)
	);

	// Consumer
	mem_dump_tx i_mem_dump_tx (
		.CLK_BUF(CLK_BUF),
		.reset_i(reset_i),
		.dump_start_i(dump_start_i),
		.dump_len_i(dump_len_i),
		.dump_data_i(dump_data),
		.dump_addr_o(dump_addr),
		.tx_o(tx_o),
		.dump_busy_o(dump_busy_o)
	);

endmodule

/* sim/periph_assertions.sv */
/*
 * Concurrent assertions on the peripheral top, bound into periph_top
 */
module periph_assertions (
	input logic                          CLK_BUF,
	input logic                          reset_i,
	input logic [mem_pkg::MEM_LANES-1:0] con_write_i,
	input logic                          frame_err_i,
	input logic                          tx_i,
	input logic                          dump_busy_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// One lane per received byte
	lane_onehot: assert property (@(posedge CLK_BUF) disable iff (reset_i)
		$onehot0(con_write_i)) else $error("con_write has more than one lane enabled");

	// Busy ends only after a stop bit
	busy_fall_high: assert property (@(posedge CLK_BUF) disable iff (reset_i)
		$fell(dump_busy_i) |-> tx_i) else $error("dump_busy_o fell while tx_o was low");

	// Line idles high outside a dump
	idle_line_high: assert property (@(posedge CLK_BUF) disable iff (reset_i)
		!dump_busy_i |-> tx_i) else $error("tx_o low while no dump is running");

	// A bad frame never writes
	no_write_on_err: assert property (@(posedge CLK_BUF) disable iff (reset_i)
		!(frame_err_i && |con_write_i)) else $error("frame_err_o and con_write active together");

endmodule

bind periph_top periph_assertions i_periph_assertions (
	.CLK_BUF(CLK_BUF),
	.reset_i(reset_i),
	.con_write_i(con_write),
	.frame_err_i(frame_err_o),
	.tx_i(tx_o),
	.dump_busy_i(dump_busy_o)
);

/* sim/periph_checker.sv */
/*
 * Checker with a shadow memory model, a tx_o frame decoder and per-test reports
 */
module periph_checker (
	input  logic                             CLK_BUF,
	input  logic                             reset_i,
	input  logic                             tx_i,
	input  logic                             frame_err_i,
	input  logic                             dump_busy_i,
	input  logic                             dump_start_i,
	input  logic [mem_pkg::MEM_ADDR_W:0]     dump_len_i,
	input  logic                             byte_stb_i,
	input  logic [uart_pkg::UART_DATA_W-1:0] byte_i,
	input  logic                             test_done_i,
	input  int                               test_id_i,
	input  int                               exp_ferr_i,
	output int                               check_cnt_o,
	output int                               err_cnt_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import mem_pkg::*;
	import uart_pkg::*;

	localparam int LANE_W = MEM_DATA_W / MEM_LANES;

	// Shadow of the data memory and of the writer's byte counter
	logic [MEM_DATA_W-1:0] shadow [MEM_DEPTH] = '{default: '0};
	int shadow_cnt = 0;
	// Bytes still due on tx_o in dump order
	logic [UART_DATA_W-1:0] exp_q [$];
	logic reset_q = 1'b0;
	// Set for one cycle after the model accepts a start
	logic start_seen = 1'b0;
	// Decoder steps through idle, start, data and stop as 0 to 3
	int dec_state = 0;
	int dec_cnt = 0;
	int dec_bit = 0;
	logic [UART_DATA_W-1:0] dec_byte = '0;
	int checks = 0;
	int errs = 0;
	int test_errs = 0;
	int test_bytes = 0;
	int test_ferr = 0;

	assign check_cnt_o = checks;
	assign err_cnt_o = errs;

	// Byte n goes to lane n mod 4 of word n / 4
	function automatic logic [MEM_DATA_W-1:0] place_byte(input logic [MEM_DATA_W-1:0] word,
		input int lane, input logic [UART_DATA_W-1:0] data);
		logic [MEM_DATA_W-1:0] res;
		res = word;
		res[lane*LANE_W +: LANE_W] = data;
		return res;
	endfunction

	task automatic count_error();
		errs++;
		test_errs++;
	endtask

	task automatic compare_byte(input logic stop_bit);
		logic [UART_DATA_W-1:0] exp_b;
		checks++;
		if (!stop_bit) begin
			$display("** Error at time %0t: tx_o stop bit expected 1 actual 0", $time);
			count_error();
		end
		if (exp_q.size() == 0) begin
			$display("Byte 0x%02h on tx_o at time %0t with no dump pending", dec_byte, $time);
			count_error();
		end else begin
			exp_b = exp_q.pop_front();
			test_bytes++;
			if (dec_byte !== exp_b) begin
				$display("** Error at time %0t: tx_o expected 0x%02h actual 0x%02h",
					$time, exp_b, dec_byte);
				count_error();
			end
		end
	endtask

	always @(posedge CLK_BUF) begin
		if (reset_i) begin
			// Counter cleared but memory kept
			shadow_cnt = 0;
			dec_state = 0;
			start_seen = 1'b0;
		end else begin
			// First cycle out of reset
			if (reset_q) begin
				checks++;
				if (tx_i !== 1'b1) begin
					$display("** Error at time %0t: tx_o expected 1 actual %b", $time, tx_i);
					count_error();
				end
			end
			if (byte_stb_i) begin
				shadow[MEM_ADDR_W'(shadow_cnt / MEM_LANES)] = place_byte(
					shadow[MEM_ADDR_W'(shadow_cnt / MEM_LANES)], shadow_cnt % MEM_LANES, byte_i);
				// Wraps after the last lane of the last word
				shadow_cnt = (shadow_cnt + 1) % (MEM_DEPTH * MEM_LANES);
			end
			// Busy due one cycle after an accepted start
			if (start_seen) begin
				checks++;
				if (dump_busy_i !== 1'b1) begin
					$display("** Error at time %0t: dump_busy_o expected 1 actual %b",
						$time, dump_busy_i);
					count_error();
				end
			end
			start_seen = 1'b0;
			// Start taken only with no dump pending and a nonzero length
			if (dump_start_i && exp_q.size() == 0 && dump_len_i != '0) begin
				start_seen = 1'b1;
				for (int w = 0; w < int'(dump_len_i); w++) begin
					for (int l = 0; l < MEM_LANES; l++) begin
						exp_q.push_back(shadow[MEM_ADDR_W'(w)][l*LANE_W +: LANE_W]);
					end
				end
			end
			if (frame_err_i) begin
				test_ferr++;
			end
			case (dec_state)
				0: begin
					if (!tx_i) begin
						dec_state = 1;
						dec_cnt = 1;
					end
				end
				1: begin
					// Middle of the start bit
					if (dec_cnt < CLKS_HALF_BIT - 1) begin
						dec_cnt++;
					end else if (tx_i) begin
						$display("Start bit on tx_o shorter than half a bit at time %0t", $time);
						count_error();
						dec_state = 0;
					end else begin
						dec_state = 2;
						dec_cnt = 1;
						dec_bit = 0;
					end
				end
				2, 3: begin
					if (dec_cnt < CLKS_PER_BIT) begin
						dec_cnt++;
					end else if (dec_state == 2) begin
						// LSB first
						dec_byte = {tx_i, dec_byte[UART_DATA_W-1:1]};
						dec_cnt = 1;
						dec_bit++;
						if (dec_bit == UART_DATA_W) begin
							dec_state = 3;
						end
					end else begin
						dec_state = 0;
						compare_byte(tx_i);
					end
				end
				default: begin
					dec_state = 0;
				end
			endcase
			if (test_done_i) begin
				checks += 2;
				if (test_ferr != exp_ferr_i) begin
					$display("** Error at time %0t: frame_err_o pulses expected %0d actual %0d",
						$time, exp_ferr_i, test_ferr);
					count_error();
				end
				if (exp_q.size() != 0) begin
					$display("** Error at time %0t: tx_o bytes expected %0d actual %0d",
						$time, test_bytes + exp_q.size(), test_bytes);
					count_error();
					exp_q.delete();
				end
				$display("Test %0d done: %0d bytes checked, %0d errors",
					test_id_i, test_bytes, test_errs);
				test_errs = 0;
				test_bytes = 0;
				test_ferr = 0;
			end
		end
		reset_q = reset_i;
	end

endmodule

/* sim/periph_tb.sv */
/*
 * Testbench for the peripheral top with serial stimulus, dumps and a watchdog
 */
module periph_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mem_pkg::*;
	import uart_pkg::*;

	localparam int CLK_PERIOD = 10;
	// Good bytes sent before the wrap test
	localparam int PRE_WRAP_BYTES = 16 + 6 + 2;
	// Runs 8 bytes past the end of memory
	localparam int WRAP_BYTES = MEM_DEPTH * MEM_LANES - PRE_WRAP_BYTES + 8;
	localparam int SENT_FRAMES = 16 + 6 + 3 + WRAP_BYTES + 2 + 4;
	localparam int DUMP_FRAMES = MEM_LANES * (4 + 6 + 6 + 8 + MEM_DEPTH + 1);
	// Ten bits a frame and doubled for gaps and resets
	localparam longint TIMEOUT_NS = longint'(SENT_FRAMES + DUMP_FRAMES) * (UART_DATA_W + 2)
		* CLKS_PER_BIT * CLK_PERIOD * 2 + 10000;

	logic CLK_BUF;
	logic reset_i;
	logic rx_i;
	logic dump_start_i;
	logic [MEM_ADDR_W:0] dump_len_i;
	logic frame_err_o;
	logic tx_o;
	logic dump_busy_o;
	// Side channel to the checker
	logic byte_stb;
	logic [UART_DATA_W-1:0] byte_val;
	logic test_done;
	int test_id;
	int exp_ferr;
	int check_cnt;
	int err_cnt;
	int tests_run;
	integer seed;

	periph_top i_periph_top (.CLK_BUF(CLK_BUF), .reset_i(reset_i), .rx_i(rx_i),
		.dump_start_i(dump_start_i), .dump_len_i(dump_len_i), .frame_err_o(frame_err_o),
		.tx_o(tx_o), .dump_busy_o(dump_busy_o));

	periph_checker i_periph_checker (.CLK_BUF(CLK_BUF), .reset_i(reset_i), .tx_i(tx_o),
		.frame_err_i(frame_err_o), .dump_busy_i(dump_busy_o), .dump_start_i(dump_start_i),
		.dump_len_i(dump_len_i), .byte_stb_i(byte_stb), .byte_i(byte_val),
		.test_done_i(test_done), .test_id_i(test_id), .exp_ferr_i(exp_ferr),
		.check_cnt_o(check_cnt), .err_cnt_o(err_cnt));

	initial begin
		CLK_BUF = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_BUF = ~CLK_BUF;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, a frame or dump never finished", TIMEOUT_NS);
		$display("TESTS FAILED");
		$finish;
	end

	// Two rising edges with reset high
	task automatic apply_reset();
		reset_i <= 1'b1;
		repeat (2) @(posedge CLK_BUF);
		reset_i <= 1'b0;
	endtask

	// One 8N1 frame where a low stop bit makes a bad frame
	task automatic send_frame(input logic [UART_DATA_W-1:0] data, input logic stop_bit);
		@(posedge CLK_BUF);
		rx_i <= 1'b0;
		byte_stb <= stop_bit;
		byte_val <= data;
		@(posedge CLK_BUF);
		byte_stb <= 1'b0;
		repeat (CLKS_PER_BIT - 1) @(posedge CLK_BUF);
		for (int i = 0; i < UART_DATA_W; i++) begin
			rx_i <= data[i];
			repeat (CLKS_PER_BIT) @(posedge CLK_BUF);
		end
		rx_i <= stop_bit;
		repeat (CLKS_PER_BIT) @(posedge CLK_BUF);
		// Idle bit lets the receiver drop the false start
		rx_i <= 1'b1;
		if (!stop_bit) begin
			repeat (CLKS_PER_BIT) @(posedge CLK_BUF);
		end
	endtask

	task automatic send_random(input int n, input logic stop_bit);
		logic [31:0] rnd;
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			send_frame(rnd[UART_DATA_W-1:0], stop_bit);
		end
	endtask

	task automatic start_dump(input int len);
		@(posedge CLK_BUF);
		dump_start_i <= 1'b1;
		dump_len_i <= len[MEM_ADDR_W:0];
		@(posedge CLK_BUF);
		dump_start_i <= 1'b0;
		while (!dump_busy_o) @(posedge CLK_BUF);
	endtask

	task automatic wait_dump_end();
		while (dump_busy_o) @(posedge CLK_BUF);
	endtask

	task automatic end_test(input int id, input int ferr);
		@(posedge CLK_BUF);
		test_done <= 1'b1;
		test_id <= id;
		exp_ferr <= ferr;
		@(posedge CLK_BUF);
		test_done <= 1'b0;
		tests_run++;
	endtask

	initial begin
		reset_i = 1'b1;
		rx_i = 1'b1;
		dump_start_i = 1'b0;
		dump_len_i = '0;
		byte_stb = 1'b0;
		byte_val = '0;
		test_done = 1'b0;
		test_id = 0;
		exp_ferr = 0;
		tests_run = 0;
		seed = 32'haa65155e;
		apply_reset();
		// Aligned words
		send_random(16, 1'b1);
		start_dump(4);
		wait_dump_end();
		end_test(1, 0);
		// Partial word leaves the upper lanes of word 5 at zero
		send_random(6, 1'b1);
		start_dump(6);
		wait_dump_end();
		end_test(2, 0);
		// Bad stop bit between two good bytes
		send_random(1, 1'b1);
		send_random(1, 1'b0);
		send_random(1, 1'b1);
		start_dump(6);
		wait_dump_end();
		end_test(3, 1);
		// Second start mid-dump is ignored
		start_dump(8);
		repeat (20 * CLKS_PER_BIT) @(posedge CLK_BUF);
		start_dump(2);
		wait_dump_end();
		end_test(4, 0);
		// Past the end of memory
		send_random(WRAP_BYTES, 1'b1);
		start_dump(MEM_DEPTH);
		wait_dump_end();
		end_test(5, 0);
		// Reset mid-word sends the counter back to word 0
		send_random(2, 1'b1);
		apply_reset();
		send_random(4, 1'b1);
		start_dump(1);
		wait_dump_end();
		end_test(6, 0);
		repeat (2) @(posedge CLK_BUF);
		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* periph_top.f */
source/mem_pkg.sv
source/uart_pkg.sv
source/uart_rx_writer.sv
source/data_mem.sv
source/mem_dump_tx.sv
source/periph_top.sv
sim/periph_assertions.sv
sim/periph_checker.sv
sim/periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the peripheral testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f periph_top.f --top-module periph_tb -Mdir "$BUILD_DIR" -o periph_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/periph_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

echo "Simulation finished, see $LOG"
exit 0
